/* cache_ctl.f */
verilog/cache_pkg.sv
verilog/cache_cfg_regs.sv
verilog/cache_store.sv
verilog/cache_ctrl_fsm.sv
verilog/wb_burst_master.sv
verilog/cache_top.sv
tb/wb_mem_model.sv
tb/cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module cache_tb -f cache_ctl.f -o cache_sim; then
        echo "Verilator build failed"
        exit 1
fi

if ! out=$(./obj_dir/cache_sim 2>&1); then
        printf '%s\n' "$out"
        echo "Simulation exited with an error status"
        exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "No errors"; then
        exit 0
else
        echo "Pass message not found in simulation output"
        exit 1
fi

/* tb/cache_tb.sv */
`timescale 1ns/100ps

module cache_tb;

import cache_pkg::*;

localparam int CLK_PERIOD   = 4;
localparam int MEM_WORDS    = 256;      // 1 KiB
localparam int N_DISABLED   = 12;
localparam int N_RANDOM     = 200;
localparam int N_UNCACHED   = 40;
localparam int TOTAL_OPS    = N_DISABLED + N_RANDOM + N_UNCACHED + 8;
localparam int WORST_CYCLES = 64;       // Dirty miss with the longest ack delays
localparam int TIMEOUT_NS   = TOTAL_OPS * WORST_CYCLES * CLK_PERIOD;

logic             clk = 1'b0;
logic             reset;
cpu_req_t         cpu_req;
cpu_rsp_t         cpu_rsp;
cfg_wr_t          cfg_wr;
wb_req_t          wb_req;
wb_rsp_t          wb_rsp;
logic [1:0]       ack_delay = 2'd0;
logic [31:0]      lfsr_q = 32'd99266;
logic [31:0]      shadow [MEM_WORDS];
logic             mdl_valid [NUM_LINES];
logic             mdl_dirty [NUM_LINES];
logic [TAG_W-1:0] mdl_tag [NUM_LINES];
logic             mdl_enable;
logic [31:0]      mdl_base;
wb_req_t          exp_beats [$];
int               beat_pos = 0;        // Beats already seen on the bus

always #(CLK_PERIOD/2) clk = ~clk;

cache_top dut_i
(
        .i_clk     (clk),
        .i_reset   (reset),
        .i_cpu_req (cpu_req),
        .o_cpu_rsp (cpu_rsp),
        .i_cfg_wr  (cfg_wr),
        .o_wb      (wb_req),
        .i_wb      (wb_rsp)
);

wb_mem_model #(.WORDS(MEM_WORDS)) mem_i
(
        .i_clk   (clk),
        .i_reset (reset),
        .i_wb    (wb_req),
        .o_wb    (wb_rsp),
        .i_delay (ack_delay)
);

// ----------------------------------------
// Random source and reference
// ----------------------------------------

// 32-bit Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
                lfsr_q = lfsr_step(lfsr_q);
                v      = {v[30:0], lfsr_q[0]};
        end
endtask

function automatic logic [31:0] ref_read(input logic [31:0] addr);
        return shadow[addr[9:2]];
endfunction

function automatic wb_req_t make_beat(input logic we, input logic [2:0] cti,
                                      input logic [31:0] adr, input logic [31:0] dat,
                                      input logic [3:0] sel);
        wb_req_t b;
        b.cyc = 1'b1;
        b.stb = 1'b1;
        b.we  = we;
        b.cti = cti;
        b.adr = adr;
        b.dat = dat;
        b.sel = sel;
        return b;
endfunction

// ----------------------------------------
// Checks
// ----------------------------------------

task automatic stop_on_error();
        $display("Errors found");
        $fatal(1);
endtask

task automatic check_rsp(input cpu_rsp_t got, input cpu_rsp_t exp);
        if (got.ack !== exp.ack || (exp.ack && got.rdata !== exp.rdata))
        begin
                $display("FAILED t=%0t o_cpu_rsp got %p expected %p", $time, got, exp);
                stop_on_error();
        end
endtask

// Address counts only on an active cycle and data and sel only on writes
task automatic check_wb(input wb_req_t got, input wb_req_t exp);
        logic bad;
        bad = got.cyc !== exp.cyc || got.stb !== exp.stb || got.we !== exp.we
              || got.cti !== exp.cti;
        if (exp.cyc && got.adr !== exp.adr)
                bad = 1'b1;
        if (exp.we && (got.dat !== exp.dat || got.sel !== exp.sel))
                bad = 1'b1;
        if (bad)
        begin
                $display("FAILED t=%0t o_wb got %p expected %p", $time, got, exp);
                stop_on_error();
        end
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
                $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
                stop_on_error();
        end
endtask

always @(posedge clk)
begin
        cpu_rsp_t exp_rsp;
        if (!reset && wb_req.cyc && wb_req.stb && wb_rsp.ack)
        begin
                if (beat_pos >= exp_beats.size())
                begin
                        $display("Unexpected Wishbone beat to %h at %0t", wb_req.adr, $time);
                        stop_on_error();
                end
                else
                begin
                        check_wb(wb_req, exp_beats[beat_pos]);
                        beat_pos = beat_pos + 1;
                end
        end
        if (!reset && cpu_rsp.ack && !cpu_req.write)
        begin
                exp_rsp.ack   = 1'b1;
                exp_rsp.rdata = ref_read(cpu_req.addr);
                check_rsp(cpu_rsp, exp_rsp);
        end
end

// ----------------------------------------
// Stimulus
// ----------------------------------------

// Queues the bus beats that the tag model predicts for one access
task automatic queue_beats(input cpu_req_t req);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        logic [31:0]        victim;
        logic [31:0]        base;
        idx = req.addr[OFFSET_W +: INDEX_W];
        tag = req.addr[31 -: TAG_W];
        if (!mdl_enable || req.addr >= mdl_base)
                exp_beats.push_back(make_beat(req.write, CTI_CLASSIC, req.addr, req.wdata,
                                              req.ben));
        else if (!mdl_valid[idx] || mdl_tag[idx] != tag)
        begin
                victim = {mdl_tag[idx], idx, 4'h0};
                base   = {tag, idx, 4'h0};
                for (int w = 0; w < WORDS_PER_LINE; w++)
                begin
                        if (mdl_valid[idx] && mdl_dirty[idx])   // Write-back first
                                exp_beats.push_back(make_beat(1'b1,
                                        (w == 3) ? CTI_EOB : CTI_BURST, victim + 4 * w,
                                        ref_read(victim + 4 * w), 4'hF));
                end
                for (int w = 0; w < WORDS_PER_LINE; w++)
                        exp_beats.push_back(make_beat(1'b0, (w == 3) ? CTI_EOB : CTI_BURST,
                                                      base + 4 * w, 32'h0, 4'h0));
                mdl_valid[idx] = 1'b1;
                mdl_tag[idx]   = tag;
                mdl_dirty[idx] = 1'b0;
        end
        if (req.write && mdl_enable && req.addr < mdl_base)
                mdl_dirty[idx] = 1'b1;
endtask

// Starts and ends on a falling edge
task automatic do_access(input logic write, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [3:0] ben);
        cpu_req_t    req;
        logic [31:0] r;
        req.valid = 1'b1;
        req.write = write;
        req.addr  = addr;
        req.wdata = wdata;
        req.ben   = ben;
        queue_beats(req);
        cpu_req = req;
        @(posedge clk);
        while (!cpu_rsp.ack)
        begin
                @(negedge clk);
                take_bits(2, r);
                ack_delay = r[1:0];   // New wait states each cycle
                @(posedge clk);
        end
        @(negedge clk);
        cpu_req.valid = 1'b0;
        if (write)
        begin
                for (int b = 0; b < 4; b++)
                begin
                        if (ben[b])
                                shadow[addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
                end
        end
        if (beat_pos != exp_beats.size())
        begin
                $display("Wishbone beats missing after access to %h", addr);
                stop_on_error();
        end
endtask

task automatic random_access(input int first_word, input int span);
        logic [31:0] r;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        take_bits(1, r);
        write = r[0];
        take_bits(10, r);
        addr = 32'((first_word + int'(r) % span) * 4);
        take_bits(32, wdata);
        take_bits(4, r);
        do_access(write, addr, wdata, r[3:0]);
endtask

task automatic write_cfg(input logic sel, input logic [31:0] data);
        cfg_wr.strobe = 1'b1;
        cfg_wr.sel    = sel;
        cfg_wr.data   = data;
        @(negedge clk);
        cfg_wr.strobe = 1'b0;
        if (sel == CFG_SEL_ENABLE)
                mdl_enable = data[0];
        else
                mdl_base = data;
endtask

initial
begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        stop_on_error();
end

initial
begin
        logic [31:0] r;
        cpu_req    = '0;
        cfg_wr     = '0;
        reset      = 1'b1;
        mdl_enable = 1'b0;
        mdl_base   = 32'hFFFF_FFFF;
        for (int i = 0; i < NUM_LINES; i++)
        begin
                mdl_valid[i] = 1'b0;
                mdl_dirty[i] = 1'b0;
                mdl_tag[i]   = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++)
        begin
                take_bits(32, r);
                shadow[i]    = r;
                mem_i.mem[i] = r;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(posedge clk);
        check_wb(wb_req, '0);   // Idle out of reset
        check_rsp(cpu_rsp, '0);
        @(negedge clk);

        for (int i = 0; i < N_DISABLED; i++)
                random_access(0, MEM_WORDS);

        write_cfg(CFG_SEL_ENABLE, 32'd1);
        do_access(1'b0, 32'h040, 32'h0, 4'h0);   // Miss then hit in the same line
        do_access(1'b0, 32'h048, 32'h0, 4'h0);
        do_access(1'b1, 32'h054, 32'hA5C3_0F1E, 4'hF);
        do_access(1'b0, 32'h154, 32'h0, 4'h0);   // Evicts dirty 0x050 line
        for (int w = 20; w < 24; w++)
                check_word("mem_i.mem", mem_i.mem[w], shadow[w]);

        // Three tags per index below 0x300
        for (int i = 0; i < N_RANDOM; i++)
                random_access(0, 192);

        write_cfg(CFG_SEL_BASE, 32'h300);
        do_access(1'b0, 32'h300, 32'h0, 4'h0);
        do_access(1'b0, 32'h304, 32'h0, 4'h0);
        for (int i = 0; i < N_UNCACHED; i++)
                random_access(0, MEM_WORDS);

        $display("No errors");
        $finish;
end

endmodule

/* tb/wb_mem_model.sv */
`timescale 1ns/100ps

module wb_mem_model
#(
        parameter int WORDS = 256
)
(
        input  logic               i_clk,
        input  logic               i_reset,
        input  cache_pkg::wb_req_t i_wb,
        output cache_pkg::wb_rsp_t o_wb,
        input  logic [1:0]         i_delay
);

logic [31:0]              mem [WORDS];   // Filled by the testbench
logic [1:0]               wait_q;
logic [$clog2(WORDS)-1:0] word_idx;

assign word_idx = i_wb.adr[2 +: $clog2(WORDS)];

// ----------------------------------------
// Slave response
// ----------------------------------------

always @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_wb.ack <= 1'b0;
                o_wb.dat <= '0;
                wait_q   <= 2'd0;
        end
        else
        begin
                o_wb.ack <= 1'b0;      // Ack is a one-cycle pulse per beat
                if (!i_wb.cyc)
                        wait_q <= i_delay;
                else if (i_wb.stb && !o_wb.ack)
                begin
                        if (wait_q != 2'd0)
                                wait_q <= wait_q - 2'd1;
                        else
                        begin
                                o_wb.ack <= 1'b1;
                                o_wb.dat <= mem[word_idx];
                                wait_q   <= i_delay;   // Delay of the next beat
                                if (i_wb.we)
                                begin
                                        for (int b = 0; b < 4; b++)
                                        begin
                                                if (i_wb.sel[b])
                                                        mem[word_idx][8*b +: 8] = i_wb.dat[8*b +: 8];
                                        end
                                end
                        end
                end
        end
end

endmodule

/* verilog/cache_cfg_regs.sv */
`timescale 1ns/100ps

module cache_cfg_regs
(
        input  logic               i_clk,
        input  logic               i_reset,
        input  cache_pkg::cfg_wr_t i_cfg_wr,
        output cache_pkg::cfg_t    o_cfg
);

import cache_pkg::*;

// ----------------------------------------
// Register file
// ----------------------------------------

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_cfg.enable   <= 1'b0;
                o_cfg.unc_base <= UNC_BASE_RESET; // Nothing uncacheable
        end
        else if (i_cfg_wr.strobe)
        begin
                if (i_cfg_wr.sel == CFG_SEL_ENABLE)
                begin
                        o_cfg.enable <= i_cfg_wr.data[0];
                end
                else if (i_cfg_wr.sel == CFG_SEL_BASE)
                begin
                        o_cfg.unc_base <= i_cfg_wr.data;
                end
        end
end

endmodule

/* verilog/cache_ctrl_fsm.sv */
`timescale 1ns/100ps

module cache_ctrl_fsm
(
        input  logic                   i_clk,
        input  logic                   i_reset,
        input  cache_pkg::cpu_req_t    i_cpu_req,
        output cache_pkg::cpu_rsp_t    o_cpu_rsp,
        input  cache_pkg::cfg_t        i_cfg,
        input  cache_pkg::tag_entry_t  i_tag,
        input  cache_pkg::cache_line_u i_line,
        output cache_pkg::store_wr_t   o_store_wr,
        output cache_pkg::burst_cmd_t  o_burst,
        input  logic                   i_burst_done,
        input  cache_pkg::cache_line_u i_fill_line,
        input  logic [31:0]            i_single_rdata
);

import cache_pkg::*;

ctl_state_e          state_q, state_d;
logic                unc_done_q;   // Single access finished last cycle
logic [TAG_W-1:0]    req_tag;
logic [INDEX_W-1:0]  req_index;
logic [1:0]          req_word;
logic                uncached;
logic                hit;
logic [31:0]         line_base;
logic [31:0]         victim_base;

// ----------------------------------------
// Request decode
// ----------------------------------------

assign req_tag     = i_cpu_req.addr[31 -: TAG_W];
assign req_index   = i_cpu_req.addr[OFFSET_W +: INDEX_W];
assign req_word    = i_cpu_req.addr[3:2];
assign uncached    = !i_cfg.enable || (i_cpu_req.addr >= i_cfg.unc_base);
assign hit         = i_tag.valid && (i_tag.tag == req_tag);
assign line_base   = {req_tag, req_index, {OFFSET_W{1'b0}}};
assign victim_base = {i_tag.tag, req_index, {OFFSET_W{1'b0}}}; // Write-back address

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_q    <= IDLE;
                unc_done_q <= 1'b0;
        end
        else
        begin
                state_q    <= state_d;
                unc_done_q <= (state_q == UNCACHED) && i_burst_done;
        end
end

always_comb
begin
        state_d         = state_q;
        o_cpu_rsp.ack   = 1'b0;
        o_cpu_rsp.rdata = (state_q == UNCACHED) ? i_single_rdata : i_line.words[req_word];
        o_store_wr      = '0;
        o_burst         = '0;
        o_burst.line    = i_line;
        o_burst.data    = i_cpu_req.wdata;
        o_burst.sel     = i_cpu_req.ben;

        case (state_q)
        IDLE:
        begin
                if (i_cpu_req.valid)
                begin
                        if (uncached)
                        begin
                                o_burst.start = 1'b1;
                                o_burst.kind  = i_cpu_req.write ? BK_SINGLE_WR : BK_SINGLE_RD;
                                o_burst.addr  = i_cpu_req.addr;
                                state_d       = UNCACHED;
                        end
                        else if (hit)
                        begin
                                o_cpu_rsp.ack = 1'b1;
                                if (i_cpu_req.write)
                                begin
                                        o_store_wr.strobe     = 1'b1;
                                        o_store_wr.index      = req_index;
                                        o_store_wr.tag        = '{1'b1, 1'b1, req_tag};
                                        o_store_wr.line.words = {WORDS_PER_LINE{i_cpu_req.wdata}};
                                        o_store_wr.mask       = LINE_BYTES'(i_cpu_req.ben)
                                                                << {req_word, 2'b00};
                                end
                        end
                        else if (i_tag.valid && i_tag.dirty)
                        begin
                                o_burst.start = 1'b1;   // Victim out first
                                o_burst.kind  = BK_LINE_WR;
                                o_burst.addr  = victim_base;
                                state_d       = CLEAN_LINE;
                        end
                        else
                        begin
                                o_burst.start = 1'b1;
                                o_burst.kind  = BK_LINE_RD;
                                o_burst.addr  = line_base;
                                state_d       = FETCH_LINE;
                        end
                end
        end

        UNCACHED:
        begin
                if (unc_done_q)
                begin
                        o_cpu_rsp.ack = 1'b1;
                        state_d       = IDLE;
                end
        end

        CLEAN_LINE:
        begin
                if (i_burst_done)
                begin
                        o_burst.start = 1'b1;
                        o_burst.kind  = BK_LINE_RD;
                        o_burst.addr  = line_base;
                        state_d       = FETCH_LINE;
                end
        end

        FETCH_LINE:
        begin
                if (i_burst_done)
                        state_d = REFILL_DONE;
        end

        REFILL_DONE:
        begin
                // Whole line in, clean; request hits back in IDLE
                o_store_wr.strobe = 1'b1;
                o_store_wr.index  = req_index;
                o_store_wr.tag    = '{1'b1, 1'b0, req_tag};
                o_store_wr.line   = i_fill_line;
                o_store_wr.mask   = '1;
                state_d           = IDLE;
        end

        default:
        begin
                state_d = IDLE;
        end
        endcase
end

endmodule

/* verilog/cache_pkg.sv */
package cache_pkg;

// ----------------------------------------
// Geometry
// ----------------------------------------
localparam int LINE_BYTES     = 16;
localparam int NUM_LINES      = 16;
localparam int WORDS_PER_LINE = 4;
localparam int OFFSET_W       = 4;
localparam int INDEX_W        = 4;
localparam int TAG_W          = 24;

// Wishbone cycle type indicator
localparam logic [2:0] CTI_CLASSIC = 3'b000;
localparam logic [2:0] CTI_BURST   = 3'b010;
localparam logic [2:0] CTI_EOB     = 3'b111;

// Burst kinds, bit 1 is line transfer and bit 0 is write
localparam logic [1:0] BK_SINGLE_RD = 2'd0;
localparam logic [1:0] BK_SINGLE_WR = 2'd1;
localparam logic [1:0] BK_LINE_RD   = 2'd2;
localparam logic [1:0] BK_LINE_WR   = 2'd3;

// Configuration register map
localparam logic        CFG_SEL_ENABLE = 1'b0;
localparam logic        CFG_SEL_BASE   = 1'b1;
localparam logic [31:0] UNC_BASE_RESET = 32'hFFFF_FFFF;

typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  ben;
} cpu_req_t;

typedef struct packed {
        logic        ack;
        logic [31:0] rdata;
} cpu_rsp_t;

typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  cti;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
} wb_req_t;

typedef struct packed {
        logic        ack;
        logic [31:0] dat;
} wb_rsp_t;

typedef struct packed {
        logic        strobe;
        logic        sel;
        logic [31:0] data;
} cfg_wr_t;

typedef struct packed {
        logic        enable;
        logic [31:0] unc_base;
} cfg_t;

typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
} tag_entry_t;

// One line, seen as words or as bytes
typedef union packed {
        logic [WORDS_PER_LINE-1:0][31:0] words;
        logic [LINE_BYTES-1:0][7:0]      bytes;
} cache_line_u;

typedef struct packed {
        logic                  strobe;
        logic [INDEX_W-1:0]    index;
        tag_entry_t            tag;
        cache_line_u           line;
        logic [LINE_BYTES-1:0] mask;
} store_wr_t;

typedef enum logic [2:0] {
        IDLE,
        UNCACHED,
        CLEAN_LINE,
        FETCH_LINE,
        REFILL_DONE
} ctl_state_e;

typedef struct packed {
        logic        start;
        logic [1:0]  kind;
        logic [31:0] addr;
        cache_line_u line;
        logic [31:0] data;
        logic [3:0]  sel;
} burst_cmd_t;

endpackage

/* verilog/cache_store.sv */
`timescale 1ns/100ps

module cache_store
(
        input  logic                          i_clk,
        input  logic                          i_reset,
        input  logic [cache_pkg::INDEX_W-1:0] i_index,
        input  cache_pkg::store_wr_t          i_wr,
        output cache_pkg::tag_entry_t         o_tag,
        output cache_pkg::cache_line_u        o_line
);

import cache_pkg::*;

logic [NUM_LINES-1:0] valid_q;
logic [NUM_LINES-1:0] dirty_q;
logic [TAG_W-1:0]     tag_q  [NUM_LINES];
cache_line_u          line_q [NUM_LINES];

// ----------------------------------------
// Asynchronous read
// ----------------------------------------

always_comb
begin
        o_tag.valid = valid_q[i_index];
        o_tag.dirty = dirty_q[i_index];
        o_tag.tag   = tag_q[i_index];
        o_line      = line_q[i_index];
end

// Status bits
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                valid_q <= '0;
                dirty_q <= '0;
        end
        else if (i_wr.strobe)
        begin
                valid_q[i_wr.index] <= i_wr.tag.valid;
                dirty_q[i_wr.index] <= i_wr.tag.dirty;
        end
end

// Tags and data, bytes merged under mask
always_ff @(posedge i_clk)
begin
        if (i_wr.strobe)
        begin
                tag_q[i_wr.index] <= i_wr.tag.tag;
                for (int b = 0; b < LINE_BYTES; b++)
                begin
                        if (i_wr.mask[b])
                                line_q[i_wr.index].bytes[b] <= i_wr.line.bytes[b];
                end
        end
end

endmodule

/* verilog/cache_top.sv */
`timescale 1ns/100ps

module cache_top
(
        input  logic                i_clk,
        input  logic                i_reset,
        input  cache_pkg::cpu_req_t i_cpu_req,
        output cache_pkg::cpu_rsp_t o_cpu_rsp,
        input  cache_pkg::cfg_wr_t  i_cfg_wr,
        output cache_pkg::wb_req_t  o_wb,
        input  cache_pkg::wb_rsp_t  i_wb
);

import cache_pkg::*;

cfg_t        cfg;
tag_entry_t  store_tag;
cache_line_u store_line;
store_wr_t   store_wr;
burst_cmd_t  burst_cmd;
logic        burst_done;
cache_line_u fill_line;
logic [31:0] single_rdata;

// ----------------------------------------
// Submodules
// ----------------------------------------

cache_cfg_regs cfg_regs_i
(
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_cfg_wr (i_cfg_wr),
        .o_cfg    (cfg)
);

// Indexed straight from the request address
cache_store store_i
(
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_index (i_cpu_req.addr[OFFSET_W +: INDEX_W]),
        .i_wr    (store_wr),
        .o_tag   (store_tag),
        .o_line  (store_line)
);

cache_ctrl_fsm ctrl_i
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_cpu_req      (i_cpu_req),
        .o_cpu_rsp      (o_cpu_rsp),
        .i_cfg          (cfg),
        .i_tag          (store_tag),
        .i_line         (store_line),
        .o_store_wr     (store_wr),
        .o_burst        (burst_cmd),
        .i_burst_done   (burst_done),
        .i_fill_line    (fill_line),
        .i_single_rdata (single_rdata)
);

wb_burst_master wb_master_i
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_cmd          (burst_cmd),
        .o_wb           (o_wb),
        .i_wb           (i_wb),
        .o_done         (burst_done),
        .o_fill_line    (fill_line),
        .o_single_rdata (single_rdata)
);

endmodule

/* verilog/wb_burst_master.sv */
`timescale 1ns/100ps

module wb_burst_master
(
        input  logic                   i_clk,
        input  logic                   i_reset,
        input  cache_pkg::burst_cmd_t  i_cmd,
        output cache_pkg::wb_req_t     o_wb,
        input  cache_pkg::wb_rsp_t     i_wb,
        output logic                   o_done,
        output cache_pkg::cache_line_u o_fill_line,
        output logic [31:0]            o_single_rdata
);

import cache_pkg::*;

wb_req_t     wb_q;
logic [1:0]  kind_q;
logic [1:0]  beat_q;
logic [1:0]  next_beat;
logic        last_beat;
logic        done_q;
cache_line_u buf_q;          // Write-back source, refill target
logic [31:0] rdata_q;

assign next_beat      = beat_q + 2'd1;
assign last_beat      = !kind_q[1] || (beat_q == 2'd3);
assign o_wb           = wb_q;
assign o_done         = done_q;
assign o_fill_line    = buf_q;
assign o_single_rdata = rdata_q;

// ----------------------------------------
// Bus sequencing
// ----------------------------------------

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                wb_q.cyc <= 1'b0;
                wb_q.stb <= 1'b0;
                wb_q.we  <= 1'b0;
                wb_q.cti <= CTI_CLASSIC;
                kind_q   <= BK_SINGLE_RD;
                beat_q   <= 2'd0;
                done_q   <= 1'b0;
        end
        else
        begin
                done_q <= 1'b0;
                if (!wb_q.cyc && i_cmd.start)
                begin
                        wb_q.cyc <= 1'b1;
                        wb_q.stb <= 1'b1;
                        wb_q.we  <= i_cmd.kind[0];
                        wb_q.cti <= i_cmd.kind[1] ? CTI_BURST : CTI_CLASSIC;
                        wb_q.adr <= i_cmd.kind[1] ? {i_cmd.addr[31:OFFSET_W], {OFFSET_W{1'b0}}}
                                                  : i_cmd.addr;
                        wb_q.dat <= i_cmd.kind[1] ? i_cmd.line.words[0] : i_cmd.data;
                        wb_q.sel <= i_cmd.kind[1] ? 4'hF : i_cmd.sel;
                        kind_q   <= i_cmd.kind;
                        beat_q   <= 2'd0;
                        buf_q    <= i_cmd.line;
                end
                else if (wb_q.cyc && i_wb.ack)
                begin
                        if (kind_q == BK_LINE_RD)
                                buf_q.words[beat_q] <= i_wb.dat;
                        if (kind_q == BK_SINGLE_RD)
                                rdata_q <= i_wb.dat;

                        if (last_beat)
                        begin
                                wb_q.cyc <= 1'b0;
                                wb_q.stb <= 1'b0;
                                wb_q.we  <= 1'b0;
                                wb_q.cti <= CTI_CLASSIC;
                                done_q   <= 1'b1;
                        end
                        else
                        begin
                                beat_q   <= next_beat;
                                wb_q.adr <= wb_q.adr + 32'd4;
                                wb_q.dat <= buf_q.words[next_beat];
                                wb_q.cti <= (next_beat == 2'd3) ? CTI_EOB : CTI_BURST;
                        end
                end
        end
end

endmodule
